// File: design/alu_operand_former.sv
/*
 * Registers the ALU control fields when a new entry enters the issue stage
 * and forms the 33-bit ALU operands from live register data. The held
 * immediate and funct3 also serve the load/store unit.
 */
`timescale 1ns/10ps

module alu_operand_former (
    input  logic                     clk,
    input  logic                     stage_load_i,
    input  issue_pkg::data_t         dec_pc_i,
    input  issue_pkg::data_t         dec_instr_i,
    input  issue_pkg::opclass_t      opclass_i,
    input  issue_pkg::fn3_t          fn3_i,
    input  issue_pkg::data_t         rs1_data_i,
    input  issue_pkg::data_t         rs2_data_i,
    output issue_pkg::alu_op_t       alu_op_o,
    output issue_pkg::alu_logic_op_t alu_logic_op_o,
    output logic                     alu_sub_o,
    output issue_pkg::ext_data_t     alu_in1_o,
    output issue_pkg::ext_data_t     alu_in2_o,
    output logic [4:0]               alu_shift_amt_o,
    output issue_pkg::data_t         alu_const_o,
    output logic                     ls_load_o,
    output logic                     ls_store_o,
    output logic [11:0]              ls_offset_o,
    output issue_pkg::fn3_t          ls_fn3_o
);
    import issue_pkg::*;

    alu_op_t       alu_op;
    alu_logic_op_t alu_logic_op;
    logic          imm_type_r;
    logic [11:0]   imm_r;
    fn3_t          fn3_r;
    logic          is_unsigned;
    data_t         in2_data;

    always_comb begin
        if (opclass_i inside {LUI_T, AUIPC_T}) begin
            alu_op = ALU_CONSTANT;
        end else begin
            case (fn3_i)
                SLT_FN3, SLTU_FN3:    alu_op = ALU_SLT;
                SLL_FN3, SRL_SRA_FN3: alu_op = ALU_SHIFT;
                default:              alu_op = ALU_ADD_SUB;
            endcase
        end
    end

    always_comb begin
        case (fn3_i)
            XOR_FN3: alu_logic_op = ALU_LOGIC_XOR;
            OR_FN3:  alu_logic_op = ALU_LOGIC_OR;
            AND_FN3: alu_logic_op = ALU_LOGIC_AND;
            default: alu_logic_op = ALU_LOGIC_ADD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (stage_load_i) begin
            alu_op_o       <= alu_op;
            alu_logic_op_o <= alu_logic_op;
            // Compares subtract as well
            alu_sub_o      <= (fn3_i inside {SLT_FN3, SLTU_FN3})
                            | ((fn3_i == ADD_SUB_FN3) & dec_instr_i[30]
                               & (opclass_i == ARITH_T));
            imm_type_r     <= opclass_i == ARITH_IMM_T;
            // S-format for stores, I-format for everything else
            imm_r          <= (opclass_i == STORE_T) ?
                              {dec_instr_i[31:25], dec_instr_i[11:7]} : dec_instr_i[31:20];
            fn3_r          <= fn3_i;
            alu_const_o    <= ((opclass_i == LUI_T) ? '0 : dec_pc_i)
                            + {dec_instr_i[31:12], 12'b0};
            ls_load_o      <= opclass_i == LOAD_T;
            ls_store_o     <= opclass_i == STORE_T;
        end
    end

    //////////////////////////////
    // Operand forming
    assign is_unsigned     = fn3_r == SLTU_FN3;
    assign in2_data        = imm_type_r ? data_t'(signed'(imm_r)) : rs2_data_i;
    assign alu_in1_o       = {rs1_data_i[XLEN-1] & ~is_unsigned, rs1_data_i};
    assign alu_in2_o       = {in2_data[XLEN-1] & ~is_unsigned, in2_data};
    assign alu_shift_amt_o = imm_type_r ? imm_r[4:0] : rs2_data_i[4:0];

    assign ls_offset_o = imm_r;
    assign ls_fn3_o    = fn3_r;

endmodule

// File: design/branch_operand_former.sv
/*
 * Branch unit inputs. Registers the sign-extended pc offset, the jump flags,
 * funct3 and pc+4 when an entry is loaded, and extends the live register
 * values for signed or unsigned compares.
 */
`timescale 1ns/10ps

module branch_operand_former (
    input  logic                 clk,
    input  logic                 stage_load_i,
    input  issue_pkg::data_t     dec_pc_i,
    input  issue_pkg::data_t     dec_instr_i,
    input  issue_pkg::opclass_t  opclass_i,
    input  issue_pkg::fn3_t      fn3_i,
    input  issue_pkg::data_t     rs1_data_i,
    input  issue_pkg::data_t     rs2_data_i,
    output issue_pkg::pc_offset_t br_offset_o,
    output logic                 br_jal_o,
    output logic                 br_jalr_o,
    output issue_pkg::fn3_t      br_fn3_o,
    output issue_pkg::ext_data_t br_rs1_o,
    output issue_pkg::ext_data_t br_rs2_o,
    output issue_pkg::data_t     br_pc_p4_o
);
    import issue_pkg::*;

    logic [19:0] jal_imm;
    logic [11:0] br_imm;
    pc_offset_t  pc_offset;
    logic        use_signed_r;

    assign jal_imm = {dec_instr_i[31], dec_instr_i[19:12], dec_instr_i[20], dec_instr_i[30:21]};
    assign br_imm  = {dec_instr_i[31], dec_instr_i[7], dec_instr_i[30:25], dec_instr_i[11:8]};

    // J, I or B format depending on the class
    always_comb begin
        case (opclass_i)
            JAL_T:   pc_offset = pc_offset_t'(signed'({jal_imm, 1'b0}));
            JALR_T:  pc_offset = pc_offset_t'(signed'(dec_instr_i[31:20]));
            default: pc_offset = pc_offset_t'(signed'({br_imm, 1'b0}));
        endcase
    end

    always_ff @(posedge clk) begin
        if (stage_load_i) begin
            br_offset_o  <= pc_offset;
            br_jal_o     <= opclass_i == JAL_T;
            br_jalr_o    <= opclass_i == JALR_T;
            br_fn3_o     <= fn3_i;
            use_signed_r <= !(fn3_i inside {BLTU_FN3, BGEU_FN3});
            br_pc_p4_o   <= dec_pc_i + 32'd4;
        end
    end

    // Extra top bit makes one signed compare serve both forms
    assign br_rs1_o = {rs1_data_i[XLEN-1] & use_signed_r, rs1_data_i};
    assign br_rs2_o = {rs2_data_i[XLEN-1] & use_signed_r, rs2_data_i};

endmodule

// File: design/decode_issue_top.sv
/*
 * Decode and issue stage of the in-order RV32I core. Connects the decoder,
 * the one-entry issue register and the ALU and branch operand formers.
 * Scoreboard flags and register data come from outside.
 */
`timescale 1ns/10ps

module decode_issue_top (
    input  logic                     clk,
    input  logic                     rst,
    // Fetch side
    input  logic                     dec_valid_i,
    output logic                     dec_ready_o,
    input  issue_pkg::data_t         dec_pc_i,
    input  issue_pkg::data_t         dec_instr_i,
    // Issue handshake
    input  issue_pkg::unit_vec_t     unit_ready_i,
    output issue_pkg::unit_vec_t     issue_valid_o,
    // Scoreboard and register file
    input  logic [1:0]               rs_inuse_i,
    output issue_pkg::reg_addr_t     issue_rs1_addr_o,
    output issue_pkg::reg_addr_t     issue_rs2_addr_o,
    input  issue_pkg::data_t         rs1_data_i,
    input  issue_pkg::data_t         rs2_data_i,
    // ALU
    output issue_pkg::alu_op_t       alu_op_o,
    output issue_pkg::alu_logic_op_t alu_logic_op_o,
    output logic                     alu_sub_o,
    output issue_pkg::ext_data_t     alu_in1_o,
    output issue_pkg::ext_data_t     alu_in2_o,
    output logic [4:0]               alu_shift_amt_o,
    output issue_pkg::data_t         alu_const_o,
    // Branch unit
    output issue_pkg::pc_offset_t    br_offset_o,
    output logic                     br_jal_o,
    output logic                     br_jalr_o,
    output issue_pkg::fn3_t          br_fn3_o,
    output issue_pkg::ext_data_t     br_rs1_o,
    output issue_pkg::ext_data_t     br_rs2_o,
    output issue_pkg::data_t         br_pc_p4_o,
    // Load/store unit
    output logic                     ls_load_o,
    output logic                     ls_store_o,
    output logic [11:0]              ls_offset_o,
    output issue_pkg::fn3_t          ls_fn3_o,
    output issue_pkg::data_t         ls_rs1_o,
    output issue_pkg::data_t         ls_rs2_o
);
    import issue_pkg::*;

    opclass_t  opclass;
    fn3_t      fn3;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      uses_rs1;
    logic      uses_rs2;
    unit_vec_t unit_needed;
    logic      stage_load;

    // Destination fields are not needed past decode here
    instr_decoder decoder_i (
        .dec_instr_i   (dec_instr_i),
        .opclass_o     (opclass),
        .fn3_o         (fn3),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rd_addr_o     (),
        .uses_rs1_o    (uses_rs1),
        .uses_rs2_o    (uses_rs2),
        .uses_rd_o     (),
        .unit_needed_o (unit_needed)
    );

    issue_stage stage_i (
        .clk              (clk),
        .rst              (rst),
        .dec_valid_i      (dec_valid_i),
        .dec_ready_o      (dec_ready_o),
        .unit_needed_i    (unit_needed),
        .uses_rs1_i       (uses_rs1),
        .uses_rs2_i       (uses_rs2),
        .rs1_addr_i       (rs1_addr),
        .rs2_addr_i       (rs2_addr),
        .rs_inuse_i       (rs_inuse_i),
        .unit_ready_i     (unit_ready_i),
        .issue_valid_o    (issue_valid_o),
        .stage_load_o     (stage_load),
        .issue_rs1_addr_o (issue_rs1_addr_o),
        .issue_rs2_addr_o (issue_rs2_addr_o)
    );

    alu_operand_former alu_former_i (
        .clk             (clk),
        .stage_load_i    (stage_load),
        .dec_pc_i        (dec_pc_i),
        .dec_instr_i     (dec_instr_i),
        .opclass_i       (opclass),
        .fn3_i           (fn3),
        .rs1_data_i      (rs1_data_i),
        .rs2_data_i      (rs2_data_i),
        .alu_op_o        (alu_op_o),
        .alu_logic_op_o  (alu_logic_op_o),
        .alu_sub_o       (alu_sub_o),
        .alu_in1_o       (alu_in1_o),
        .alu_in2_o       (alu_in2_o),
        .alu_shift_amt_o (alu_shift_amt_o),
        .alu_const_o     (alu_const_o),
        .ls_load_o       (ls_load_o),
        .ls_store_o      (ls_store_o),
        .ls_offset_o     (ls_offset_o),
        .ls_fn3_o        (ls_fn3_o)
    );

    branch_operand_former br_former_i (
        .clk          (clk),
        .stage_load_i (stage_load),
        .dec_pc_i     (dec_pc_i),
        .dec_instr_i  (dec_instr_i),
        .opclass_i    (opclass),
        .fn3_i        (fn3),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .br_offset_o  (br_offset_o),
        .br_jal_o     (br_jal_o),
        .br_jalr_o    (br_jalr_o),
        .br_fn3_o     (br_fn3_o),
        .br_rs1_o     (br_rs1_o),
        .br_rs2_o     (br_rs2_o),
        .br_pc_p4_o   (br_pc_p4_o)
    );

    // Address and store data straight from the register file
    assign ls_rs1_o = rs1_data_i;
    assign ls_rs2_o = rs2_data_i;

endmodule

// File: design/instr_decoder.sv
/*
 * Combinational decode of one RV32I instruction word. Extracts the register
 * fields, classifies the opcode and picks the execution unit. Unsupported
 * instructions select no unit at all.
 */
`timescale 1ns/10ps

module instr_decoder (
    input  issue_pkg::data_t     dec_instr_i,
    output issue_pkg::opclass_t  opclass_o,
    output issue_pkg::fn3_t      fn3_o,
    output issue_pkg::reg_addr_t rs1_addr_o,
    output issue_pkg::reg_addr_t rs2_addr_o,
    output issue_pkg::reg_addr_t rd_addr_o,
    output logic                 uses_rs1_o,
    output logic                 uses_rs2_o,
    output logic                 uses_rd_o,
    output issue_pkg::unit_vec_t unit_needed_o
);
    import issue_pkg::*;

    opclass_t opclass;
    logic     mul_div_op;

    //////////////////////////////
    // Field extraction
    assign opclass    = opclass_t'(dec_instr_i[6:2]);
    assign opclass_o  = opclass;
    assign fn3_o      = dec_instr_i[14:12];
    assign rs1_addr_o = dec_instr_i[19:15];
    assign rs2_addr_o = dec_instr_i[24:20];
    assign rd_addr_o  = dec_instr_i[11:7];

    // M extension shares the ARITH opcode
    assign mul_div_op = (opclass == ARITH_T) & dec_instr_i[25];

    //////////////////////////////
    // Register use
    assign uses_rs1_o = opclass inside {JALR_T, BRANCH_T, LOAD_T, STORE_T,
                                        ARITH_IMM_T, ARITH_T};

    // Stores read rs2 as the store data
    assign uses_rs2_o = opclass inside {BRANCH_T, STORE_T, ARITH_T};

    assign uses_rd_o = opclass inside {LUI_T, AUIPC_T, JAL_T, JALR_T, LOAD_T,
                                       ARITH_IMM_T, ARITH_T};

    //////////////////////////////
    // Unit selection
    always_comb begin
        unit_needed_o = '0;
        unit_needed_o[UNIT_ALU] = (opclass inside {LUI_T, AUIPC_T, ARITH_IMM_T})
                                | ((opclass == ARITH_T) & ~mul_div_op);
        unit_needed_o[UNIT_BR]  = opclass inside {BRANCH_T, JAL_T, JALR_T};
        unit_needed_o[UNIT_LS]  = opclass inside {LOAD_T, STORE_T};
    end

endmodule

// File: design/issue_pkg.sv
/*
 * Shared widths, opcode classes, funct3 codes and unit encodings for the
 * RV32I decode and issue stage. Every design file imports what it needs
 * from here.
 */
package issue_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_UNITS = 3;

    // Bit positions in the unit vectors
    localparam int UNIT_ALU = 0;
    localparam int UNIT_BR  = 1;
    localparam int UNIT_LS  = 2;

    typedef logic [XLEN-1:0]      data_t;
    typedef logic [XLEN:0]        ext_data_t;
    typedef logic [4:0]           reg_addr_t;
    typedef logic [2:0]           fn3_t;
    typedef logic [NUM_UNITS-1:0] unit_vec_t;
    typedef logic signed [20:0]   pc_offset_t;

    // Instruction bits 6:2
    typedef enum logic [4:0] {
        LOAD_T      = 5'b00000,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011
    } opclass_t;

    localparam fn3_t ADD_SUB_FN3 = 3'b000;
    localparam fn3_t SLL_FN3     = 3'b001;
    localparam fn3_t SLT_FN3     = 3'b010;
    localparam fn3_t SLTU_FN3    = 3'b011;
    localparam fn3_t XOR_FN3     = 3'b100;
    localparam fn3_t SRL_SRA_FN3 = 3'b101;
    localparam fn3_t OR_FN3      = 3'b110;
    localparam fn3_t AND_FN3     = 3'b111;
    localparam fn3_t BLTU_FN3    = 3'b110;
    localparam fn3_t BGEU_FN3    = 3'b111;

    typedef enum logic [1:0] {
        ALU_CONSTANT = 2'b00,
        ALU_ADD_SUB  = 2'b01,
        ALU_SLT      = 2'b10,
        ALU_SHIFT    = 2'b11
    } alu_op_t;

    typedef enum logic [1:0] {
        ALU_LOGIC_XOR = 2'b00,
        ALU_LOGIC_OR  = 2'b01,
        ALU_LOGIC_AND = 2'b10,
        ALU_LOGIC_ADD = 2'b11
    } alu_logic_op_t;

endpackage

// File: design/issue_stage.sv
/*
 * One-entry issue register between decode and the execution units.
 * Holds the entry until its sources are free and the target unit is ready,
 * and drops entries that need no unit one cycle after acceptance.
 */
`timescale 1ns/10ps

module issue_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dec_valid_i,
    output logic                 dec_ready_o,
    input  issue_pkg::unit_vec_t unit_needed_i,
    input  logic                 uses_rs1_i,
    input  logic                 uses_rs2_i,
    input  issue_pkg::reg_addr_t rs1_addr_i,
    input  issue_pkg::reg_addr_t rs2_addr_i,
    input  logic [1:0]           rs_inuse_i,
    input  issue_pkg::unit_vec_t unit_ready_i,
    output issue_pkg::unit_vec_t issue_valid_o,
    output logic                 stage_load_o,
    output issue_pkg::reg_addr_t issue_rs1_addr_o,
    output issue_pkg::reg_addr_t issue_rs2_addr_o
);
    import issue_pkg::*;

    logic       stage_valid;
    unit_vec_t  unit_r;
    logic [1:0] uses_rs_r;
    reg_addr_t  rs1_addr_r;
    reg_addr_t  rs2_addr_r;

    logic [1:0] rs_conflict;
    logic       operands_ready;
    logic       issued;
    logic       discard;
    logic       stage_ready;

    //////////////////////////////
    // Operand hazards
    // Only sources the held instruction reads can block it
    assign rs_conflict    = rs_inuse_i & uses_rs_r;
    assign operands_ready = ~|rs_conflict;

    //////////////////////////////
    // Issue requests
    assign issue_valid_o = {NUM_UNITS{stage_valid & operands_ready}} & unit_r;
    assign issued        = |(issue_valid_o & unit_ready_i);
    assign discard       = stage_valid & ~|unit_r;

    // Free on a handshake or when the entry has nowhere to go
    assign stage_ready  = ~stage_valid | issued | discard;
    assign dec_ready_o  = stage_ready;
    assign stage_load_o = dec_valid_i & stage_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (stage_ready) begin
            stage_valid <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_load_o) begin
            unit_r     <= unit_needed_i;
            uses_rs_r  <= {uses_rs2_i, uses_rs1_i};
            rs1_addr_r <= rs1_addr_i;
            rs2_addr_r <= rs2_addr_i;
        end
    end

    // Register file read addresses for the held entry
    assign issue_rs1_addr_o = rs1_addr_r;
    assign issue_rs2_addr_o = rs2_addr_r;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the decode/issue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module decode_issue_tb \
    -f src.f -o decode_issue_sim > sim.log 2>&1 \
    && ./obj_dir/decode_issue_sim >> sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1

// File: sim/decode_issue_asserts.sv
/*
 * Concurrent checks bound into the decode and issue top level. Covers the
 * one-hot issue request, request stability under back-pressure and the
 * empty stage after reset.
 */
`timescale 1ns/10ps

module decode_issue_asserts (
    input logic                 clk,
    input logic                 rst,
    input issue_pkg::unit_vec_t issue_valid_i,
    input issue_pkg::unit_vec_t unit_ready_i,
    input issue_pkg::reg_addr_t rs1_addr_i,
    input issue_pkg::ext_data_t alu_in1_i,
    input issue_pkg::ext_data_t alu_in2_i,
    input issue_pkg::pc_offset_t br_offset_i,
    input logic [11:0]          ls_offset_i
);

    a_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot0(issue_valid_i))
        else $error("more than one issue request");

    // Pending request keeps its unit and operands
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (issue_valid_i != '0 && (issue_valid_i & unit_ready_i) == '0)
        |=> (issue_valid_i == $past(issue_valid_i)) && $stable(rs1_addr_i)
            && $stable(alu_in1_i) && $stable(alu_in2_i)
            && $stable(br_offset_i) && $stable(ls_offset_i))
        else $error("request changed without a handshake");

    a_reset: assert property (@(posedge clk) $fell(rst) |-> issue_valid_i == '0)
        else $error("issue request right after reset");

endmodule

// File: sim/decode_issue_tb.sv
/*
 * Testbench for the decode and issue stage. Applies an instruction table in
 * order with LFSR-driven unit back-pressure and scoreboard hazards, models
 * the register file, and checks every issue against values built from the
 * instruction encoding.
 */
`timescale 1ns/10ps

module decode_issue_tb;
    import issue_pkg::*;

    logic clk;
    logic rst;
    logic dec_valid_i, dec_ready_o;
    data_t dec_pc_i, dec_instr_i, rs1_data_i, rs2_data_i;
    unit_vec_t unit_ready_i, issue_valid_o;
    logic [1:0] rs_inuse_i;
    reg_addr_t issue_rs1_addr_o, issue_rs2_addr_o;
    alu_op_t alu_op_o;
    alu_logic_op_t alu_logic_op_o;
    logic alu_sub_o, br_jal_o, br_jalr_o, ls_load_o, ls_store_o;
    ext_data_t alu_in1_o, alu_in2_o, br_rs1_o, br_rs2_o;
    logic [4:0] alu_shift_amt_o;
    data_t alu_const_o, br_pc_p4_o, ls_rs1_o, ls_rs2_o;
    pc_offset_t br_offset_o;
    fn3_t br_fn3_o, ls_fn3_o;
    logic [11:0] ls_offset_o;

    // Table columns are pc, instruction, expected unit vector and expected alu_op
    data_t       tbl_pc[$];
    data_t       tbl_instr[$];
    unit_vec_t   tbl_unit[$];
    logic [1:0]  tbl_op[$];
    int          exp_q[$];
    logic [7:0]  lfsr;
    int          cycles;
    int          idx;

    decode_issue_top DUT (.*);

    bind decode_issue_top decode_issue_asserts asserts_i (
        .clk(clk), .rst(rst), .issue_valid_i(issue_valid_o),
        .unit_ready_i(unit_ready_i), .rs1_addr_i(issue_rs1_addr_o),
        .alu_in1_i(alu_in1_o), .alu_in2_i(alu_in2_o),
        .br_offset_i(br_offset_o), .ls_offset_i(ls_offset_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // Register file model and helpers
    function automatic data_t reg_value(input reg_addr_t a);
        return (32'(a) * 32'h9E3779B1) ^ 32'h5A5AC3C3;
    endfunction

    assign rs1_data_i = reg_value(issue_rs1_addr_o);
    assign rs2_data_i = reg_value(issue_rs2_addr_o);

    function automatic logic random_bit();
        logic b;
        b    = lfsr[0];
        lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        return b;
    endfunction

    function automatic data_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input fn3_t f3,
                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic data_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                     input fn3_t f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic data_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input fn3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic data_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input fn3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic data_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic add_entry(input data_t instr, input unit_vec_t unit,
                             input logic [1:0] op);
        tbl_pc.push_back(32'h0000_1000 + 32'(4 * tbl_pc.size()));
        tbl_instr.push_back(instr);
        tbl_unit.push_back(unit);
        tbl_op.push_back(op);
    endtask

    task automatic stop_with_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    //////////////////////////////
    // Held entry, its register addresses and hazard gating
    task automatic check_request(input int e);
        data_t instr;
        logic [6:0] opc;
        logic [1:0] uses;
        instr   = tbl_instr[e];
        opc     = instr[6:0];
        uses[0] = !(opc inside {7'h37, 7'h17, 7'h6f});
        uses[1] = opc inside {7'h63, 7'h23, 7'h33};
        assert (issue_rs1_addr_o == instr[19:15] && issue_rs2_addr_o == instr[24:20])
            else stop_with_error($sformatf("entry %0d register addresses wrong", e));
        if ((rs_inuse_i & uses) != '0) begin
            assert (issue_valid_o == '0)
                else stop_with_error($sformatf("entry %0d requested over a hazard", e));
        end else begin
            assert (issue_valid_o == tbl_unit[e])
                else stop_with_error($sformatf("entry %0d requested %b", e, issue_valid_o));
        end
    endtask

    //////////////////////////////
    // Expected values from the encoding
    task automatic check_issue();
        int e;
        data_t instr, pc, r1, r2, b, imm, upper;
        logic imm_form, uns, sub;
        logic [1:0] lop;
        pc_offset_t off;
        e     = exp_q.pop_front();
        instr = tbl_instr[e];
        pc    = tbl_pc[e];
        r1    = reg_value(instr[19:15]);
        r2    = reg_value(instr[24:20]);
        imm   = {{20{instr[31]}}, instr[31:20]};
        upper = {instr[31:12], 12'b0};
        if (tbl_unit[e] == 3'b001) begin
            assert (alu_op_o == tbl_op[e])
                else stop_with_error($sformatf("entry %0d alu_op %0d", e, alu_op_o));
            if (instr[6:0] == 7'h37) begin
                assert (alu_const_o == upper)
                    else stop_with_error($sformatf("entry %0d const %h", e, alu_const_o));
            end else if (instr[6:0] == 7'h17) begin
                assert (alu_const_o == pc + upper)
                    else stop_with_error($sformatf("entry %0d const %h", e, alu_const_o));
            end else begin
                imm_form = instr[6:0] == 7'h13;
                uns      = instr[14:12] == 3'b011;
                sub      = instr[14:13] == 2'b01
                           || (instr[14:12] == 3'b000 && !imm_form && instr[30]);
                lop      = instr[14:12] == 3'b100 ? 2'd0 : instr[14:12] == 3'b110 ? 2'd1 :
                           instr[14:12] == 3'b111 ? 2'd2 : 2'd3;
                b        = imm_form ? imm : r2;
                assert (alu_logic_op_o == lop && alu_sub_o == sub)
                    else stop_with_error($sformatf("entry %0d logic/sub wrong", e));
                assert (alu_in1_o == {r1[31] & ~uns, r1} && alu_in2_o == {b[31] & ~uns, b})
                    else stop_with_error($sformatf("entry %0d ALU operands wrong", e));
                assert (instr[14:12] != 3'b001
                        || alu_shift_amt_o == (imm_form ? instr[24:20] : r2[4:0]))
                    else stop_with_error($sformatf("entry %0d shift amount wrong", e));
            end
        end else if (tbl_unit[e] == 3'b010) begin
            if (instr[6:0] == 7'h6f)
                off = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            else if (instr[6:0] == 7'h67)
                off = {{9{instr[31]}}, instr[31:20]};
            else
                off = {{8{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            uns = instr[14:13] == 2'b11;
            assert (br_offset_o == off && br_pc_p4_o == pc + 32'd4)
                else stop_with_error($sformatf("entry %0d offset %h", e, br_offset_o));
            assert (br_jal_o == (instr[6:0] == 7'h6f) && br_jalr_o == (instr[6:0] == 7'h67))
                else stop_with_error($sformatf("entry %0d jump flags wrong", e));
            assert (instr[6:0] != 7'h63 || (br_fn3_o == instr[14:12]
                    && br_rs1_o == {r1[31] & ~uns, r1} && br_rs2_o == {r2[31] & ~uns, r2}))
                else stop_with_error($sformatf("entry %0d compare operands wrong", e));
        end else begin
            assert (ls_store_o == (instr[6:0] == 7'h23) && ls_load_o == (instr[6:0] == 7'h03))
                else stop_with_error($sformatf("entry %0d load/store flag wrong", e));
            assert (ls_offset_o == (instr[6:0] == 7'h23 ? {instr[31:25], instr[11:7]}
                                                         : instr[31:20])
                    && ls_fn3_o == instr[14:12] && ls_rs1_o == r1 && ls_rs2_o == r2)
                else stop_with_error($sformatf("entry %0d load/store fields wrong", e));
        end
    endtask

    // Watchdog sized from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 40 * tbl_pc.size() + 20) begin
            $display("Timeout: the instruction table did not drain in time");
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////
    // Stimulus
    initial begin
        rst          = 1'b1;
        dec_valid_i  = 1'b0;
        dec_pc_i     = '0;
        dec_instr_i  = '0;
        unit_ready_i = '0;
        rs_inuse_i   = '0;
        lfsr         = 8'd58;
        cycles       = 0;
        idx          = 0;
        add_entry(i_type(12'hffb, 2, 3'd0, 1, 7'h13), 3'b001, 2'd1);
        add_entry(r_type(7'h00, 3, 4, 3'd0, 5), 3'b001, 2'd1);
        add_entry(r_type(7'h20, 6, 7, 3'd0, 8), 3'b001, 2'd1);
        add_entry(r_type(7'h00, 9, 10, 3'd2, 11), 3'b001, 2'd2);
        add_entry(r_type(7'h00, 12, 13, 3'd3, 14), 3'b001, 2'd2);
        add_entry(r_type(7'h00, 15, 16, 3'd4, 17), 3'b001, 2'd1);
        add_entry(r_type(7'h00, 18, 19, 3'd6, 20), 3'b001, 2'd1);
        add_entry(r_type(7'h00, 1, 2, 3'd7, 3), 3'b001, 2'd1);
        add_entry(r_type(7'h00, 21, 22, 3'd1, 23), 3'b001, 2'd3);
        add_entry(i_type(12'h007, 24, 3'd1, 25, 7'h13), 3'b001, 2'd3);
        add_entry(i_type(12'h800, 26, 3'd3, 27, 7'h13), 3'b001, 2'd2);
        add_entry({20'hABCDE, 5'd1, 7'h37}, 3'b001, 2'd0);
        add_entry({20'h80001, 5'd2, 7'h17}, 3'b001, 2'd0);
        add_entry(32'h0000_0073, 3'b000, 2'd0);
        add_entry(j_type(21'h1FFFF0, 1), 3'b010, 2'd0);
        add_entry(i_type(12'h804, 5, 3'd0, 1, 7'h67), 3'b010, 2'd0);
        add_entry(b_type(13'h0010, 3, 4, 3'd0), 3'b010, 2'd0);
        add_entry(b_type(13'h1FF8, 28, 29, 3'd4), 3'b010, 2'd0);
        add_entry(b_type(13'h0FFE, 30, 31, 3'd6), 3'b010, 2'd0);
        add_entry(32'h0000_000f, 3'b000, 2'd0);
        add_entry(i_type(12'h7F0, 8, 3'd2, 9, 7'h03), 3'b100, 2'd0);
        add_entry(s_type(12'hF81, 10, 11, 3'd0), 3'b100, 2'd0);
        add_entry(r_type(7'h01, 3, 4, 3'd0, 5), 3'b000, 2'd0);
        add_entry(b_type(13'h0100, 30, 31, 3'd7), 3'b010, 2'd0);
        add_entry(i_type(12'h004, 31, 3'd4, 1, 7'h03), 3'b100, 2'd0);
        repeat (5) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        while (idx < tbl_pc.size() || exp_q.size() != 0) begin
            @(negedge clk);
            dec_valid_i = idx < tbl_pc.size();
            if (dec_valid_i) begin
                dec_pc_i    = tbl_pc[idx];
                dec_instr_i = tbl_instr[idx];
            end
            for (int u = 0; u < NUM_UNITS; u++)
                unit_ready_i[u] = random_bit();
            // Scoreboard flags only change while nothing is requested
            if (issue_valid_o == '0) begin
                rs_inuse_i[0] = random_bit() & random_bit();
                rs_inuse_i[1] = random_bit() & random_bit();
            end
            #1;
            // An empty or discarding stage requests nothing and takes the next entry
            if (exp_q.size() != 0) begin
                check_request(exp_q[0]);
            end else begin
                assert (issue_valid_o == '0 && dec_ready_o)
                    else stop_with_error("request or stall with no entry to issue");
            end
            if (|(issue_valid_o & unit_ready_i)) begin
                check_issue();
            end else if (exp_q.size() != 0) begin
                assert (!dec_ready_o)
                    else stop_with_error("dec_ready_o high while the entry is blocked");
            end
            if (dec_valid_i && dec_ready_o) begin
                if (tbl_unit[idx] != '0)
                    exp_q.push_back(idx);
                idx++;
            end
        end
        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: src.f
design/issue_pkg.sv
design/instr_decoder.sv
design/issue_stage.sv
design/alu_operand_former.sv
design/branch_operand_former.sv
design/decode_issue_top.sv
sim/decode_issue_asserts.sv
sim/decode_issue_tb.sv
